// ==== Bender.yml ====
package:
  name: gpu

sources:
  - logic/gpu_pkg.sv
  - logic/ram_port_if.sv
  - logic/block_ram.sv
  - logic/host_interface.sv
  - logic/shader_core.sv
  - logic/gpu.sv
  - target: simulation
    files:
      - sim/clock_gen.sv
      - sim/gpu_assertions.sv
      - sim/gpu_tb.sv

// ==== flist.f ====
logic/gpu_pkg.sv
logic/ram_port_if.sv
logic/block_ram.sv
logic/host_interface.sv
logic/shader_core.sv
logic/gpu.sv
sim/clock_gen.sv
sim/gpu_assertions.sv
sim/gpu_tb.sv

// ==== logic/block_ram.sv ====
`timescale 1ns/10ps

module block_ram #(
    parameter int RAM_ADDR_WIDTH = 10
) (
    input  logic       clock,
    ram_port_if.memory port
);
    import gpu_pkg::*;

    localparam int DEPTH = 2 ** RAM_ADDR_WIDTH;

    logic [WORD_WIDTH-1:0] mem [DEPTH];

    // Write on strobe
    always_ff @(posedge clock) begin
        if (port.write) begin
            mem[port.address] <= port.write_data;
        end
    end

    // Read port registered every cycle, old data on a write to the same word
    always_ff @(posedge clock) begin
        port.read_data <= mem[port.address];
    end

endmodule

// ==== logic/gpu.sv ====
`timescale 1ns/10ps

module gpu #(
    parameter int RAM_ADDR_WIDTH = 10
) (
    input  logic                           clock,
    input  logic                           arst_n,
    input  logic [gpu_pkg::WORD_WIDTH-1:0] h2f_value,
    output logic [gpu_pkg::WORD_WIDTH-1:0] f2h_value,
    output logic                           run,
    output logic                           halted,
    output logic                           exception,
    output logic [23:0]                    exception_data
);

    ram_port_if #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) host_inst ();
    ram_port_if #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) host_data ();
    ram_port_if #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) core_inst ();
    ram_port_if #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) core_data ();
    ram_port_if #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) inst_mem ();
    ram_port_if #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) data_mem ();

    block_ram #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) i_inst_ram (
        .clock (clock),
        .port  (inst_mem.memory)
    );

    block_ram #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) i_data_ram (
        .clock (clock),
        .port  (data_mem.memory)
    );

    host_interface #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) i_host (
        .clock     (clock),
        .arst_n    (arst_n),
        .h2f_value (h2f_value),
        .f2h_value (f2h_value),
        .run       (run),
        .inst_port (host_inst.requester),
        .data_port (host_data.requester)
    );

    shader_core #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) i_core (
        .clock          (clock),
        .arst_n         (arst_n),
        .run            (run),
        .halted         (halted),
        .exception      (exception),
        .exception_data (exception_data),
        .inst_port      (core_inst.requester),
        .data_port      (core_data.requester)
    );

    // Host owns both RAMs while stopped, the core while running
    assign inst_mem.address    = run ? core_inst.address : host_inst.address;
    assign inst_mem.write      = run ? core_inst.write : host_inst.write;
    assign inst_mem.write_data = run ? core_inst.write_data : host_inst.write_data;

    assign data_mem.address    = run ? core_data.address : host_data.address;
    assign data_mem.write      = run ? core_data.write : host_data.write;
    assign data_mem.write_data = run ? core_data.write_data : host_data.write_data;

    // Read data fans out to both requesters
    assign host_inst.read_data = inst_mem.read_data;
    assign core_inst.read_data = inst_mem.read_data;
    assign host_data.read_data = data_mem.read_data;
    assign core_data.read_data = data_mem.read_data;

endmodule

// ==== logic/gpu_pkg.sv ====
package gpu_pkg;

    localparam int WORD_WIDTH = 32;

    // Host command word layout
    localparam int CMD_TOGGLE_BIT    = 31;
    localparam int CMD_CODE_MSB      = 30;
    localparam int CMD_CODE_LSB      = 28;
    localparam int CMD_PAYLOAD_WIDTH = 16;

    // Host command codes
    localparam logic [2:0] CMD_SET_ADDR   = 3'd0;
    localparam logic [2:0] CMD_SET_LOW    = 3'd1;
    localparam logic [2:0] CMD_SET_HIGH   = 3'd2;
    localparam logic [2:0] CMD_WRITE_INST = 3'd3;
    localparam logic [2:0] CMD_WRITE_DATA = 3'd4;
    localparam logic [2:0] CMD_READ_INST  = 3'd5;
    localparam logic [2:0] CMD_READ_DATA  = 3'd6;
    localparam logic [2:0] CMD_CONTROL    = 3'd7;

    // Register form
    localparam logic [3:0] OP_ADD  = 4'h0;
    localparam logic [3:0] OP_SUB  = 4'h1;
    localparam logic [3:0] OP_AND  = 4'h2;
    localparam logic [3:0] OP_OR   = 4'h3;
    localparam logic [3:0] OP_XOR  = 4'h4;
    // Immediate form
    localparam logic [3:0] OP_ADDI = 4'h5;
    localparam logic [3:0] OP_LW   = 4'h6;
    localparam logic [3:0] OP_SW   = 4'h7;
    localparam logic [3:0] OP_BNE  = 4'h8;
    // Codes 9 to 14 are undefined
    localparam logic [3:0] OP_HALT = 4'hf;

    // One instruction word, two views
    typedef union packed {
        struct packed {
            logic [3:0]  opcode;
            logic [2:0]  rd;
            logic [2:0]  rs1;
            logic [2:0]  rs2;
            logic [18:0] unused;
        } r;
        struct packed {
            logic [3:0]         opcode;
            logic [2:0]         rd;
            logic [2:0]         rs1;
            logic [5:0]         unused;
            logic signed [15:0] imm;
        } i;
    } instr_t;

endpackage

// ==== logic/host_interface.sv ====
`timescale 1ns/10ps

module host_interface #(
    parameter int RAM_ADDR_WIDTH = 10
) (
    input  logic                           clock,
    input  logic                           arst_n,
    input  logic [gpu_pkg::WORD_WIDTH-1:0] h2f_value,
    output logic [gpu_pkg::WORD_WIDTH-1:0] f2h_value,
    output logic                           run,
    ram_port_if.requester                  inst_port,
    ram_port_if.requester                  data_port
);
    import gpu_pkg::*;

    logic                         last_toggle;
    logic                         accept;
    logic                         take;
    logic                         is_write;
    logic                         is_read;
    logic [2:0]                   code;
    logic [CMD_PAYLOAD_WIDTH-1:0] payload;
    logic [RAM_ADDR_WIDTH-1:0]    addr_reg;
    logic [WORD_WIDTH-1:0]        data_reg;
    logic                         ctrl_pending;
    logic                         ctrl_run;
    logic                         read_issue;
    logic                         read_issue_inst;
    logic [RAM_ADDR_WIDTH-1:0]    port_addr;
    logic [WORD_WIDTH-1:0]        port_wdata;
    logic                         inst_write;
    logic                         data_write;
    logic [1:0]                   read_pipe;
    logic [1:0]                   read_pipe_inst;

    // New command whenever the toggle bit flips
    assign accept  = h2f_value[CMD_TOGGLE_BIT] != last_toggle;
    assign code    = h2f_value[CMD_CODE_MSB:CMD_CODE_LSB];
    assign payload = h2f_value[CMD_PAYLOAD_WIDTH-1:0];

    // Only CONTROL gets through while the core runs
    assign take     = accept && !run;
    assign is_write = code == CMD_WRITE_INST || code == CMD_WRITE_DATA;
    assign is_read  = code == CMD_READ_INST || code == CMD_READ_DATA;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            last_toggle     <= 1'b0;
            run             <= 1'b0;
            ctrl_pending    <= 1'b0;
            ctrl_run        <= 1'b0;
            addr_reg        <= '0;
            inst_write      <= 1'b0;
            data_write      <= 1'b0;
            read_issue      <= 1'b0;
            read_issue_inst <= 1'b0;
        end else begin
            inst_write   <= take && code == CMD_WRITE_INST;
            data_write   <= take && code == CMD_WRITE_DATA;
            read_issue   <= take && is_read;
            ctrl_pending <= accept && code == CMD_CONTROL;
            if (accept) begin
                last_toggle <= h2f_value[CMD_TOGGLE_BIT];
                ctrl_run    <= payload[0];
            end
            if (take) begin
                read_issue_inst <= code == CMD_READ_INST;
            end
            // Run follows one cycle behind the accepted CONTROL
            if (ctrl_pending) begin
                run <= ctrl_run;
            end
            // Writes step the address at once, reads when they are issued
            if (take && code == CMD_SET_ADDR) begin
                addr_reg <= payload[RAM_ADDR_WIDTH-1:0];
            end else if ((take && is_write) || read_issue) begin
                addr_reg <= addr_reg + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (take && code == CMD_SET_LOW) begin
            data_reg[CMD_PAYLOAD_WIDTH-1:0] <= payload;
        end
        if (take && code == CMD_SET_HIGH) begin
            data_reg[WORD_WIDTH-1:CMD_PAYLOAD_WIDTH] <= payload;
        end
        if (take && is_write) begin
            port_addr  <= addr_reg;
            port_wdata <= data_reg;
        end else if (read_issue) begin
            port_addr <= addr_reg;
        end
    end

    // Two stages follow a read through the RAM, the second one lands the word
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            read_pipe      <= '0;
            read_pipe_inst <= '0;
            f2h_value      <= '0;
        end else begin
            read_pipe      <= {read_pipe[0], read_issue};
            read_pipe_inst <= {read_pipe_inst[0], read_issue_inst};
            if (read_pipe[1]) begin
                f2h_value <= read_pipe_inst[1] ? inst_port.read_data : data_port.read_data;
            end
        end
    end

    // Both ports share address and data, strobes are separate
    assign inst_port.address    = port_addr;
    assign inst_port.write      = inst_write;
    assign inst_port.write_data = port_wdata;
    assign data_port.address    = port_addr;
    assign data_port.write      = data_write;
    assign data_port.write_data = port_wdata;

endmodule

// ==== logic/ram_port_if.sv ====
`timescale 1ns/10ps

interface ram_port_if #(
    parameter int RAM_ADDR_WIDTH = 10
);
    import gpu_pkg::*;

    logic [RAM_ADDR_WIDTH-1:0] address;
    logic                      write;
    logic [WORD_WIDTH-1:0]     write_data;
    logic [WORD_WIDTH-1:0]     read_data;

    modport requester (
        output address,
        output write,
        output write_data,
        input  read_data
    );

    modport memory (
        input  address,
        input  write,
        input  write_data,
        output read_data
    );

endinterface

// ==== logic/shader_core.sv ====
`timescale 1ns/10ps

module shader_core #(
    parameter int RAM_ADDR_WIDTH = 10
) (
    input  logic          clock,
    input  logic          arst_n,
    input  logic          run,
    output logic          halted,
    output logic          exception,
    output logic [23:0]   exception_data,
    ram_port_if.requester inst_port,
    ram_port_if.requester data_port
);
    import gpu_pkg::*;

    localparam logic [2:0] S_IDLE      = 3'd0;
    localparam logic [2:0] S_FETCH     = 3'd1;
    localparam logic [2:0] S_EXECUTE   = 3'd2;
    localparam logic [2:0] S_LOAD_WAIT = 3'd3;
    localparam logic [2:0] S_HALTED    = 3'd4;
    localparam logic [2:0] S_FAULT     = 3'd5;

    logic [2:0]                state;
    logic [RAM_ADDR_WIDTH-1:0] pc;
    logic [RAM_ADDR_WIDTH-1:0] next_pc;
    logic [RAM_ADDR_WIDTH-1:0] branch_pc;
    logic [WORD_WIDTH-1:0]     regs [8];
    logic [2:0]                load_rd;
    logic                      start;
    instr_t                    instr;
    logic [WORD_WIDTH-1:0]     rs1_val;
    logic [WORD_WIDTH-1:0]     rs2_val;
    logic [WORD_WIDTH-1:0]     rd_val;
    logic [WORD_WIDTH-1:0]     imm_ext;
    logic [WORD_WIDTH-1:0]     mem_sum;
    logic [WORD_WIDTH-1:0]     alu_result;
    logic                      alu_write;

    // Registered RAM output is the word fetched at pc
    assign instr = inst_port.read_data;

    assign start     = state == S_IDLE && run;
    assign rs1_val   = regs[instr.r.rs1];
    assign rs2_val   = regs[instr.r.rs2];
    assign rd_val    = regs[instr.i.rd];
    assign imm_ext   = {{(WORD_WIDTH - 16){instr.i.imm[15]}}, instr.i.imm};
    assign mem_sum   = rs1_val + imm_ext;
    assign next_pc   = pc + 1'b1;
    assign branch_pc = next_pc + imm_ext[RAM_ADDR_WIDTH-1:0];

    always_comb begin
        alu_result = '0;
        alu_write  = 1'b1;
        case (instr.r.opcode)
            OP_ADD:  alu_result = rs1_val + rs2_val;
            OP_SUB:  alu_result = rs1_val - rs2_val;
            OP_AND:  alu_result = rs1_val & rs2_val;
            OP_OR:   alu_result = rs1_val | rs2_val;
            OP_XOR:  alu_result = rs1_val ^ rs2_val;
            OP_ADDI: alu_result = rs1_val + imm_ext;
            default: alu_write = 1'b0;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state          <= S_IDLE;
            pc             <= '0;
            exception_data <= '0;
        end else if (!run) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    state          <= S_FETCH;
                    pc             <= '0;
                    exception_data <= '0;
                end
                S_FETCH: begin
                    state <= S_EXECUTE;
                end
                S_EXECUTE: begin
                    case (instr.i.opcode)
                        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_SW: begin
                            state <= S_FETCH;
                            pc    <= next_pc;
                        end
                        OP_LW: begin
                            state <= S_LOAD_WAIT;
                            pc    <= next_pc;
                        end
                        OP_BNE: begin
                            state <= S_FETCH;
                            pc    <= (rd_val != rs1_val) ? branch_pc : next_pc;
                        end
                        OP_HALT: begin
                            state <= S_HALTED;
                        end
                        default: begin
                            // pc stays on the faulting word
                            state          <= S_FAULT;
                            exception_data <= {4'b0, instr.i.opcode, 16'(pc)};
                        end
                    endcase
                end
                S_LOAD_WAIT: begin
                    state <= S_FETCH;
                end
                default: begin
                    // Halted or faulted until run drops
                    state <= state;
                end
            endcase
        end
    end

    // Register file, cleared on every start; r0 is never written
    always_ff @(posedge clock) begin
        if (start) begin
            for (int k = 0; k < 8; k++) begin
                regs[k] <= '0;
            end
        end else if (state == S_EXECUTE && alu_write && instr.r.rd != 3'd0) begin
            regs[instr.r.rd] <= alu_result;
        end else if (state == S_LOAD_WAIT && load_rd != 3'd0) begin
            regs[load_rd] <= data_port.read_data;
        end
        if (state == S_EXECUTE) begin
            load_rd <= instr.i.rd;
        end
    end

    assign halted    = state == S_HALTED;
    assign exception = state == S_FAULT;

    // Program store is read only from here
    assign inst_port.address    = pc;
    assign inst_port.write      = 1'b0;
    assign inst_port.write_data = '0;

    assign data_port.address    = mem_sum[RAM_ADDR_WIDTH-1:0];
    assign data_port.write      = state == S_EXECUTE && instr.i.opcode == OP_SW;
    assign data_port.write_data = rd_val;

endmodule

// ==== sim/clock_gen.sv ====
`timescale 1ns/10ps

module clock_gen #(
    parameter int HALF_PERIOD_NS = 20,
    parameter int RESET_CYCLES   = 4
) (
    output logic clock,
    output logic arst_n
);

    initial begin
        clock = 1'b0;
        forever #(HALF_PERIOD_NS) clock = ~clock;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
    end

endmodule

// ==== sim/gpu_assertions.sv ====
`timescale 1ns/10ps

module gpu_assertions (
    input logic        clock,
    input logic        arst_n,
    input logic        run,
    input logic        halted,
    input logic        exception,
    input logic [23:0] exception_data,
    input logic        host_inst_write,
    input logic        host_data_write
);

    // End flags hold while the core is still running
    a_flags_held: assert property (@(posedge clock) disable iff (!arst_n)
        (halted || exception) && run |=> $stable({halted, exception}))
        else $error("halted or exception changed while run is high");

    // Fault info frozen until the core is stopped
    a_exc_data_stable: assert property (@(posedge clock) disable iff (!arst_n)
        exception && $past(exception) |-> $stable(exception_data))
        else $error("exception_data changed while exception is high");

    a_no_host_write: assert property (@(posedge clock) disable iff (!arst_n)
        run |-> !host_inst_write && !host_data_write)
        else $error("host port wrote a RAM while the core runs");

    a_stop_clears: assert property (@(posedge clock) disable iff (!arst_n)
        $fell(run) |=> !halted && !exception)
        else $error("halted or exception still high one cycle after run fell");

endmodule

// ==== sim/gpu_tb.sv ====
`timescale 1ns/10ps

module gpu_tb;
    import gpu_pkg::*;

    localparam int         ADDR_W  = 10;
    localparam int         DEPTH   = 2 ** ADDR_W;
    localparam logic [1:0] K_RESET = 2'd0;
    localparam logic [1:0] K_CMD   = 2'd1;
    localparam logic [1:0] K_WAIT  = 2'd2;

    typedef struct packed {
        logic [1:0]  kind;
        logic [2:0]  code;
        logic [15:0] payload;
        logic [31:0] exp_f2h;
        logic        exp_run;
        logic        exp_exc;
        logic [23:0] exp_exc_data;
    } step_t;

    logic        clock;
    logic        arst_n;
    logic [31:0] h2f_value;
    logic [31:0] f2h_value;
    logic        run;
    logic        halted;
    logic        exception;
    logic [23:0] exception_data;

    step_t       steps[$];
    logic [31:0] prog[$];

    // Reference model state for the host side and the ISA
    logic [31:0]       m_inst[DEPTH];
    logic [31:0]       m_data[DEPTH];
    logic [ADDR_W-1:0] m_addr;
    logic [31:0]       m_word;
    logic [31:0]       m_f2h;
    logic              m_run;
    logic              m_ended;
    logic              m_exc;
    logic [23:0]       m_exc_data;

    clock_gen i_clock_gen (
        .clock  (clock),
        .arst_n (arst_n)
    );

    gpu #(.RAM_ADDR_WIDTH(ADDR_W)) i_dut (
        .clock          (clock),
        .arst_n         (arst_n),
        .h2f_value      (h2f_value),
        .f2h_value      (f2h_value),
        .run            (run),
        .halted         (halted),
        .exception      (exception),
        .exception_data (exception_data)
    );

    bind gpu gpu_assertions i_assertions (
        .clock           (clock),
        .arst_n          (arst_n),
        .run             (run),
        .halted          (halted),
        .exception       (exception),
        .exception_data  (exception_data),
        .host_inst_write (host_inst.write),
        .host_data_write (host_data.write)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("FAILED at %0t ns: %s is 0x%08h, expected 0x%08h",
                                $time, name, actual, expected));
        end
    endtask

    function automatic logic [31:0] assemble_reg(input logic [3:0] op, input logic [2:0] rd,
                                                 input logic [2:0] rs1, input logic [2:0] rs2);
        instr_t w;
        w          = '0;
        w.r.opcode = op;
        w.r.rd     = rd;
        w.r.rs1    = rs1;
        w.r.rs2    = rs2;
        return w;
    endfunction

    function automatic logic [31:0] assemble_imm(input logic [3:0] op, input logic [2:0] rd,
                                                 input logic [2:0] rs1, input logic [15:0] imm);
        instr_t w;
        w          = '0;
        w.i.opcode = op;
        w.i.rd     = rd;
        w.i.rs1    = rs1;
        w.i.imm    = imm;
        return w;
    endfunction

    // Appends one host command and what the host side should show after it
    task automatic push_command(input logic [2:0] code, input logic [15:0] payload);
        step_t s;
        if (!m_run || code == CMD_CONTROL) begin
            case (code)
                CMD_SET_ADDR:   m_addr = payload[ADDR_W-1:0];
                CMD_SET_LOW:    m_word[15:0] = payload;
                CMD_SET_HIGH:   m_word[31:16] = payload;
                CMD_WRITE_INST: m_inst[m_addr] = m_word;
                CMD_WRITE_DATA: m_data[m_addr] = m_word;
                CMD_READ_INST:  m_f2h = m_inst[m_addr];
                CMD_READ_DATA:  m_f2h = m_data[m_addr];
                CMD_CONTROL:    m_run = payload[0];
            endcase
            if (code inside {CMD_WRITE_INST, CMD_WRITE_DATA, CMD_READ_INST, CMD_READ_DATA}) begin
                m_addr = m_addr + 1'b1;
            end
        end
        s         = '0;
        s.kind    = K_CMD;
        s.code    = code;
        s.payload = payload;
        s.exp_f2h = m_f2h;
        s.exp_run = m_run;
        steps.push_back(s);
    endtask

    task automatic load_word(input logic [2:0] code, input logic [31:0] value);
        push_command(CMD_SET_LOW, value[15:0]);
        push_command(CMD_SET_HIGH, value[31:16]);
        push_command(code, 16'h0000);
    endtask

    task automatic read_back(input logic [2:0] code, input logic [15:0] addr, input int count);
        push_command(CMD_SET_ADDR, addr);
        repeat (count) push_command(code, 16'h0000);
    endtask

    task automatic load_program();
        push_command(CMD_SET_ADDR, 16'h0000);
        foreach (prog[k]) load_word(CMD_WRITE_INST, prog[k]);
        prog.delete();
    endtask

    // ISA reference model
    // A program still looping after 2000 steps counts as running
    task automatic run_model();
        logic [31:0]       r[8];
        logic [ADDR_W-1:0] pc;
        logic [ADDR_W-1:0] ea;
        logic [31:0]       imm;
        instr_t            w;
        int                count;
        foreach (r[k]) r[k] = '0;
        pc         = '0;
        count      = 0;
        m_ended    = 1'b0;
        m_exc      = 1'b0;
        m_exc_data = '0;
        while (!m_ended && count < 2000) begin
            w     = m_inst[pc];
            imm   = {{16{w.i.imm[15]}}, w.i.imm};
            ea    = ADDR_W'(r[w.i.rs1] + imm);
            count = count + 1;
            case (w.r.opcode)
                OP_ADD:  r[w.r.rd] = r[w.r.rs1] + r[w.r.rs2];
                OP_SUB:  r[w.r.rd] = r[w.r.rs1] - r[w.r.rs2];
                OP_AND:  r[w.r.rd] = r[w.r.rs1] & r[w.r.rs2];
                OP_OR:   r[w.r.rd] = r[w.r.rs1] | r[w.r.rs2];
                OP_XOR:  r[w.r.rd] = r[w.r.rs1] ^ r[w.r.rs2];
                OP_ADDI: r[w.i.rd] = r[w.i.rs1] + imm;
                OP_LW:   r[w.i.rd] = m_data[ea];
                OP_SW:   m_data[ea] = r[w.i.rd];
                OP_BNE:  if (r[w.i.rd] != r[w.i.rs1]) pc = pc + ADDR_W'(imm);
                OP_HALT: m_ended = 1'b1;
                default: begin
                    m_ended    = 1'b1;
                    m_exc      = 1'b1;
                    m_exc_data = {4'h0, w.r.opcode, 16'(pc)};
                end
            endcase
            r[0] = '0;
            if (!m_ended) pc = pc + 1'b1;
        end
    endtask

    task automatic start_program();
        step_t s;
        push_command(CMD_CONTROL, 16'h0001);
        run_model();
        if (m_ended) begin
            s              = '0;
            s.kind         = K_WAIT;
            s.exp_run      = 1'b1;
            s.exp_exc      = m_exc;
            s.exp_exc_data = m_exc_data;
            steps.push_back(s);
        end
    endtask

    task automatic build_table();
        step_t       s;
        logic [31:0] value;
        s = '0;
        steps.push_back(s);
        // Same addresses in both RAMs with different random words
        push_command(CMD_SET_ADDR, 16'h0100);
        repeat (8) load_word(CMD_WRITE_INST, $urandom());
        push_command(CMD_SET_ADDR, 16'h0100);
        repeat (8) load_word(CMD_WRITE_DATA, $urandom());
        read_back(CMD_READ_INST, 16'h0100, 8);
        read_back(CMD_READ_DATA, 16'h0100, 8);
        // Endless BNE loop while the host tries to write and read
        prog.push_back(assemble_imm(OP_ADDI, 3'd1, 3'd0, 16'h0001));
        prog.push_back(assemble_imm(OP_BNE, 3'd1, 3'd0, 16'hffff));
        load_program();
        start_program();
        push_command(CMD_SET_ADDR, 16'h0100);
        load_word(CMD_WRITE_DATA, 32'hdead_beef);
        read_back(CMD_READ_DATA, 16'h0100, 2);
        push_command(CMD_CONTROL, 16'h0000);
        read_back(CMD_READ_DATA, 16'h0100, 2);
        // ALU ops with r1 positive so r1 + r2 wraps
        value = $urandom();
        prog.push_back(assemble_imm(OP_ADDI, 3'd1, 3'd0, {2'b01, value[13:0]}));
        prog.push_back(assemble_imm(OP_ADDI, 3'd2, 3'd0, 16'hfffd));
        prog.push_back(assemble_reg(OP_ADD, 3'd3, 3'd1, 3'd2));
        prog.push_back(assemble_reg(OP_SUB, 3'd4, 3'd2, 3'd1));
        prog.push_back(assemble_reg(OP_AND, 3'd5, 3'd1, 3'd2));
        prog.push_back(assemble_reg(OP_OR, 3'd6, 3'd1, 3'd2));
        prog.push_back(assemble_reg(OP_XOR, 3'd7, 3'd1, 3'd2));
        prog.push_back(assemble_imm(OP_ADDI, 3'd0, 3'd1, 16'h0005));
        for (int k = 0; k < 8; k++) begin
            prog.push_back(assemble_imm(OP_SW, 3'(k), 3'd0, 16'(16'h0040 + k)));
        end
        prog.push_back(assemble_imm(OP_HALT, 3'd0, 3'd0, 16'h0000));
        load_program();
        start_program();
        push_command(CMD_CONTROL, 16'h0000);
        read_back(CMD_READ_DATA, 16'h0040, 8);
        // Sum of five table words through LW and a BNE loop
        push_command(CMD_SET_ADDR, 16'h0080);
        repeat (5) load_word(CMD_WRITE_DATA, $urandom());
        prog.push_back(assemble_imm(OP_ADDI, 3'd1, 3'd0, 16'h0080));
        prog.push_back(assemble_imm(OP_ADDI, 3'd2, 3'd0, 16'h0005));
        prog.push_back(assemble_imm(OP_LW, 3'd4, 3'd1, 16'h0000));
        prog.push_back(assemble_reg(OP_ADD, 3'd3, 3'd3, 3'd4));
        prog.push_back(assemble_imm(OP_ADDI, 3'd1, 3'd1, 16'h0001));
        prog.push_back(assemble_imm(OP_ADDI, 3'd2, 3'd2, 16'hffff));
        prog.push_back(assemble_imm(OP_BNE, 3'd2, 3'd0, 16'hfffb));
        prog.push_back(assemble_imm(OP_SW, 3'd3, 3'd0, 16'h0090));
        prog.push_back(assemble_imm(OP_HALT, 3'd0, 3'd0, 16'h0000));
        load_program();
        start_program();
        push_command(CMD_CONTROL, 16'h0000);
        read_back(CMD_READ_DATA, 16'h0090, 1);
        // Undefined opcode 0xb at pc 2
        prog.push_back(assemble_imm(OP_ADDI, 3'd1, 3'd0, 16'h0003));
        prog.push_back(assemble_imm(OP_ADDI, 3'd2, 3'd1, 16'h0004));
        prog.push_back(32'hb123_4567);
        prog.push_back(assemble_imm(OP_HALT, 3'd0, 3'd0, 16'h0000));
        load_program();
        start_program();
        push_command(CMD_CONTROL, 16'h0000);
    endtask

    task automatic apply_step(input step_t s);
        int cycles;
        case (s.kind)
            K_RESET: begin
                check_value("run", run, 32'd0);
                check_value("halted", halted, 32'd0);
                check_value("exception", exception, 32'd0);
                check_value("exception_data", exception_data, 32'd0);
                check_value("f2h_value", f2h_value, 32'd0);
            end
            K_CMD: begin
                h2f_value = {~h2f_value[CMD_TOGGLE_BIT], s.code, 12'h000, s.payload};
                repeat (4) @(negedge clock);
                check_value("f2h_value", f2h_value, s.exp_f2h);
                check_value("run", run, s.exp_run);
                if (!s.exp_run) begin
                    check_value("halted", halted, 32'd0);
                    check_value("exception", exception, 32'd0);
                end
            end
            default: begin
                cycles = 0;
                while (!halted && !exception) begin
                    if (cycles == 2000) begin
                        abort_run("Timeout: neither halted nor exception rose in 2000 cycles");
                    end
                    @(negedge clock);
                    cycles = cycles + 1;
                end
                check_value("run", run, s.exp_run);
                check_value("exception", exception, s.exp_exc);
                check_value("halted", halted, !s.exp_exc);
                check_value("exception_data", exception_data, s.exp_exc_data);
            end
        endcase
    endtask

    initial begin
        int cycles;
        h2f_value = '0;
        m_addr    = '0;
        m_word    = '0;
        m_f2h     = '0;
        m_run     = 1'b0;
        void'($urandom(57));
        build_table();
        cycles = 0;
        while (arst_n !== 1'b1) begin
            if (cycles == 20) begin
                abort_run("Timeout: reset was never released");
            end
            @(posedge clock);
            cycles = cycles + 1;
        end
        @(negedge clock);
        foreach (steps[k]) apply_step(steps[k]);
        $display("Result: PASSED");
        $finish;
    end

endmodule
